// File: compile.f
verilog/cpu_pkg.sv
verilog/pc_unit.sv
verilog/instr_mem.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/alu_flags.sv
verilog/cpu_core.sv
tests/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the core and its testbench with Verilator, runs it and scans the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module cpu_tb \
  --Mdir obj_dir \
  -o cpu_tb_sim

./obj_dir/cpu_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// File: tests/cpu_tb.sv
// Testbench for cpu_core, loads short programs from a table and steps them.
// An ISA model predicts pc, writeback and flags for every cycle.
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  localparam int k_wb = 0;   // row writes a register
  localparam int k_br = 1;   // row only moves the pc
  localparam int k_halt = 2; // last row of a program

  logic                       clk;
  logic                       rst_n;
  logic                       run;
  logic                       prog_we;
  logic [cpu_pkg::data_w-1:0] prog_addr;
  logic [cpu_pkg::data_w-1:0] prog_data;
  logic [cpu_pkg::data_w-1:0] pc_addr;
  logic                       halted;
  logic                       wb_en;
  logic [cpu_pkg::reg_w-1:0]  wb_reg;
  logic [cpu_pkg::data_w-1:0] wb_data;
  logic [cpu_pkg::flag_w-1:0] flags;

  // program table
  logic [15:0] rows_word [$];
  int          rows_kind [$];
  bit          rows_rnd  [$]; // imm8 replaced by a random byte

  // model state
  logic [15:0] prog_img [256];
  logic [15:0] m_pc;
  logic [15:0] m_regs [16];
  logic [2:0]  m_flags;
  logic        e_en;
  logic [3:0]  e_reg;
  logic [15:0] e_res;
  logic [15:0] e_npc;
  logic [2:0]  e_flags;
  logic [31:0] rnd_state;

  cpu_core #(.imem_depth(256)) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc_addr   (pc_addr),
    .halted    (halted),
    .wb_en     (wb_en),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .flags     (flags)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] enc_alu(cpu_pkg::opcode_e op, int rd, int rs, int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  function automatic logic [15:0] enc_lli(int rd, logic [7:0] imm);
    return {cpu_pkg::op_lli, 4'(rd), imm};
  endfunction

  function automatic logic [15:0] enc_b(cpu_pkg::cond_e c, logic [7:0] imm);
    return {cpu_pkg::op_b, 1'b0, c, imm};
  endfunction

  function automatic logic [15:0] enc_br(cpu_pkg::cond_e c, int rs);
    return {cpu_pkg::op_br, 1'b0, c, 4'(rs), 4'b0};
  endfunction

  // branch conditions in their textbook form
  function automatic bit cond_holds(logic [2:0] c, logic [2:0] f);
    bit z, n, v;
    z = f[0];
    n = f[1];
    v = f[2];
    case (c)
      3'd0: return !z;
      3'd1: return z;
      3'd2: return !z && !n;
      3'd3: return n;
      3'd4: return !n;
      3'd5: return n || z;
      3'd6: return v;
      default: return 1'b1;
    endcase
  endfunction

  task automatic add_row(logic [15:0] w, int kind, bit rnd);
    rows_word.push_back(w);
    rows_kind.push_back(kind);
    rows_rnd.push_back(rnd);
  endtask

  task automatic fail_value(string msg);
    $display("ERR @%0t: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_pc(logic [cpu_pkg::data_w-1:0] got, logic [cpu_pkg::data_w-1:0] exp);
    if (got !== exp) begin
      fail_value($sformatf("pc_addr %h, expected %h", got, exp));
    end
  endtask

  task automatic check_wb(logic en, logic [cpu_pkg::reg_w-1:0] r, logic [cpu_pkg::data_w-1:0] d,
                          logic x_en, logic [cpu_pkg::reg_w-1:0] x_r,
                          logic [cpu_pkg::data_w-1:0] x_d);
    if (en !== x_en || (x_en && (r !== x_r || d !== x_d))) begin
      fail_value($sformatf("wb en %b r%0d %h, expected en %b r%0d %h", en, r, d, x_en, x_r, x_d));
    end
  endtask

  task automatic check_flags(logic [cpu_pkg::flag_w-1:0] got, logic [cpu_pkg::flag_w-1:0] exp);
    if (got !== exp) begin
      fail_value($sformatf("flags vnz %b, expected %b", got, exp));
    end
  endtask

  task automatic check_halt(logic got, logic exp);
    if (got !== exp) begin
      fail_value($sformatf("halted %b, expected %b", got, exp));
    end
  endtask

  // one instruction of the ISA, from the model state
  task automatic model_step();
    logic [15:0] w, a, b;
    int s;
    w = prog_img[m_pc[15:1]];
    a = m_regs[w[7:4]];
    b = m_regs[w[3:0]];
    e_en = 1'b0;
    e_reg = w[11:8];
    e_res = '0;
    e_flags = m_flags;
    e_npc = m_pc + 16'd2;
    case (w[15:12])
      4'h0, 4'h1: begin
        s = w[12] ? int'($signed(a)) - int'($signed(b))
                  : int'($signed(a)) + int'($signed(b));
        e_res = 16'(s);
        e_en = 1'b1;
        e_flags = {(s > 32767 || s < -32768), e_res[15], e_res == 16'h0};
      end
      4'h2: begin
        e_res = a ^ b;
        e_en = 1'b1;
        e_flags = {1'b0, e_res[15], e_res == 16'h0}; // v cleared
      end
      4'h3: begin
        e_res = {8'h00, w[7:0]};
        e_en = 1'b1;
      end
      4'hc: if (cond_holds(w[10:8], m_flags)) e_npc = m_pc + 16'd2 + {8'h00, w[7:0]};
      4'hd: if (cond_holds(w[10:8], m_flags)) e_npc = a;
      4'hf: e_npc = m_pc;
      default: ; // no-op
    endcase
  endtask

  task automatic run_program(int first, int last);
    logic [15:0] w;
    int step;
    bit done;
    rst_n = 1'b0;
    run = 1'b0;
    prog_we = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    for (int i = first; i <= last; i++) begin
      w = rows_word[i];
      if (rows_rnd[i]) begin
        rnd_state = xorshift(rnd_state);
        w[7:0] = rnd_state[7:0];
      end
      prog_img[i - first] = w;
      prog_we = 1'b1;
      prog_addr = 16'(i - first);
      prog_data = w;
      #1;
      check_pc(pc_addr, 16'h0000); // pc parked while loading
      check_wb(wb_en, wb_reg, wb_data, 1'b0, '0, '0);
      @(negedge clk);
    end
    prog_we = 1'b0;
    m_pc = '0;
    m_flags = '0;
    foreach (m_regs[r]) m_regs[r] = '0;
    run = 1'b1;
    step = 0;
    done = 1'b0;
    while (!done) begin
      if (step == 3) begin
        run = 1'b0; // freeze mid program
        repeat (2) begin
          #1;
          check_pc(pc_addr, m_pc);
          check_wb(wb_en, wb_reg, wb_data, 1'b0, '0, '0);
          check_flags(flags, m_flags);
          @(negedge clk);
        end
        run = 1'b1;
      end
      #1;
      model_step();
      check_pc(pc_addr, m_pc);
      check_wb(wb_en, wb_reg, wb_data, e_en, e_reg, e_res);
      check_flags(flags, m_flags);
      if (rows_kind[first + m_pc[15:1]] == k_halt) begin
        check_halt(halted, 1'b1);
        repeat (3) begin
          @(negedge clk);
          #1;
          check_pc(pc_addr, m_pc);
          check_halt(halted, 1'b1);
        end
        done = 1'b1;
      end else begin
        check_halt(halted, 1'b0);
        if (e_en) m_regs[e_reg] = e_res;
        m_flags = e_flags;
        m_pc = e_npc;
        @(negedge clk);
        step++;
        if (step > 64) begin
          $display("program starting at row %0d never reached its halt", first);
          $display("STATUS: FAIL");
          $fatal(1);
        end
      end
    end
    @(negedge clk);
    run = 1'b0;
  endtask

  task automatic build_table();
    add_row(enc_lli(1, 8'hff), k_wb, 0);
    for (int r = 2; r <= 9; r++) add_row(enc_alu(cpu_pkg::op_add, r, r - 1, r - 1), k_wb, 0);
    add_row(enc_b(cpu_pkg::cond_ov, 8'h02), k_br, 0); // v set by the last doubling
    add_row(enc_lli(1, 8'h00), k_wb, 0);
    add_row(enc_alu(cpu_pkg::op_sub, 10, 9, 8), k_wb, 0); // neg minus pos overflow
    add_row(enc_b(cpu_pkg::cond_al, 8'h02), k_br, 0);
    add_row(16'h5abc, k_br, 0);
    add_row(enc_lli(11, 8'h00), k_wb, 1);
    add_row(enc_lli(12, 8'h00), k_wb, 1);
    add_row(enc_alu(cpu_pkg::op_add, 13, 11, 12), k_wb, 0);
    add_row(enc_alu(cpu_pkg::op_sub, 14, 11, 12), k_wb, 0);
    add_row(enc_alu(cpu_pkg::op_xor, 15, 11, 12), k_wb, 0);
    add_row(enc_alu(cpu_pkg::op_xor, 0, 11, 11), k_wb, 0); // z set, v cleared
    add_row(enc_b(cpu_pkg::cond_ov, 8'h02), k_br, 0);
    add_row(16'hf000, k_halt, 0);
    // every condition against zero, negative and positive results
    add_row(enc_lli(1, 8'h05), k_wb, 0);
    add_row(enc_lli(2, 8'h05), k_wb, 0);
    add_row(enc_alu(cpu_pkg::op_sub, 3, 1, 2), k_wb, 0);
    add_row(enc_b(cpu_pkg::cond_eq, 8'h02), k_br, 0);
    add_row(16'h6123, k_br, 0);
    add_row(enc_b(cpu_pkg::cond_ne, 8'h02), k_br, 0);
    add_row(enc_b(cpu_pkg::cond_ge, 8'h02), k_br, 0);
    add_row(enc_lli(4, 8'h11), k_wb, 0);
    add_row(enc_b(cpu_pkg::cond_gt, 8'h02), k_br, 0);
    add_row(enc_b(cpu_pkg::cond_le, 8'h02), k_br, 0);
    add_row(16'h7000, k_br, 0);
    add_row(enc_alu(cpu_pkg::op_sub, 5, 0, 1), k_wb, 0);
    add_row(enc_b(cpu_pkg::cond_lt, 8'h02), k_br, 0);
    add_row(16'h8000, k_br, 0);
    add_row(enc_b(cpu_pkg::cond_ge, 8'h02), k_br, 0);
    add_row(enc_b(cpu_pkg::cond_gt, 8'h02), k_br, 0);
    add_row(enc_b(cpu_pkg::cond_le, 8'h02), k_br, 0);
    add_row(16'h9fff, k_br, 0);
    add_row(enc_alu(cpu_pkg::op_sub, 6, 1, 0), k_wb, 0);
    add_row(enc_b(cpu_pkg::cond_gt, 8'h02), k_br, 0);
    add_row(16'ha000, k_br, 0);
    add_row(16'hb123, k_br, 0); // unknown code, flags must hold
    add_row(enc_b(cpu_pkg::cond_ne, 8'h02), k_br, 0);
    add_row(enc_lli(7, 8'h22), k_wb, 0);
    add_row(16'hf000, k_halt, 0);
    // register branches
    add_row(enc_lli(1, 8'h08), k_wb, 0);
    add_row(enc_br(cpu_pkg::cond_al, 1), k_br, 0);
    add_row(16'h5555, k_br, 0);
    add_row(enc_lli(2, 8'h77), k_wb, 0);
    add_row(enc_lli(3, 8'h33), k_wb, 0);
    add_row(enc_br(cpu_pkg::cond_eq, 3), k_br, 0); // z clear, falls through
    add_row(enc_lli(4, 8'd20), k_wb, 0);
    add_row(enc_alu(cpu_pkg::op_sub, 5, 3, 3), k_wb, 0);
    add_row(enc_br(cpu_pkg::cond_eq, 4), k_br, 0);
    add_row(16'he000, k_br, 0);
    add_row(16'hf000, k_halt, 0);
  endtask

  initial begin
    int first;
    rst_n = 1'b0;
    run = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    rnd_state = 32'd1918;
    build_table();
    first = 0;
    foreach (rows_kind[i]) begin
      if (rows_kind[i] == k_halt) begin
        run_program(first, i);
        first = i + 1;
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

  // watchdog, four cycles per row plus the resets
  initial begin
    int nprog;
    int limit;
    #1;
    nprog = 0;
    foreach (rows_kind[i]) if (rows_kind[i] == k_halt) nprog++;
    limit = (rows_word.size() * 4 + 8 * (nprog + 1)) * 8;
    #(limit);
    $display("simulation timed out after %0d ns", limit);
    $display("STATUS: FAIL");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: verilog/cpu_core.sv
// Top of the single-cycle core, one instruction fetched and retired per clock.
// Program is loaded through prog_we while run is low.
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
  parameter int imem_depth = 256 // instruction words
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        run,       // low holds all state
  input  wire logic                        prog_we,
  input  wire logic [cpu_pkg::data_w-1:0]  prog_addr, // word index
  input  wire logic [cpu_pkg::data_w-1:0]  prog_data,
  output logic      [cpu_pkg::data_w-1:0]  pc_addr,
  output logic                             halted,
  output logic                             wb_en,
  output logic      [cpu_pkg::reg_w-1:0]   wb_reg,
  output logic      [cpu_pkg::data_w-1:0]  wb_data,
  output logic      [cpu_pkg::flag_w-1:0]  flags
);

  logic [cpu_pkg::data_w-1:0] instr;
  cpu_pkg::opcode_e           opcode;
  cpu_pkg::opcode_e           alu_op;
  cpu_pkg::cond_e             cond;
  logic [cpu_pkg::reg_w-1:0]  rs;
  logic [cpu_pkg::reg_w-1:0]  rt;
  logic [cpu_pkg::imm_w-1:0]  imm8;
  logic [cpu_pkg::data_w-1:0] rs_data;
  logic [cpu_pkg::data_w-1:0] rt_data;

  pc_unit u_pc (
    .clk             (clk),
    .rst_n           (rst_n),
    .run             (run),
    .opcode          (opcode),
    .cond            (cond),
    .imm8            (imm8),
    .flags           (flags),
    .branch_reg_addr (rs_data), // br target
    .pc_addr         (pc_addr),
    .halted          (halted)
  );

  instr_mem #(.imem_depth(imem_depth)) u_imem (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc_addr   (pc_addr),
    .instr     (instr)
  );

  inst_decode u_dec (
    .instr  (instr),
    .run    (run),
    .opcode (opcode),
    .alu_op (alu_op),
    .cond   (cond),
    .rd     (wb_reg), // destination goes out as-is
    .rs     (rs),
    .rt     (rt),
    .imm8   (imm8),
    .wb_en  (wb_en)
  );

  reg_file u_rf (
    .clk     (clk),
    .rst_n   (rst_n),
    .we      (wb_en),
    .waddr   (wb_reg),
    .wdata   (wb_data),
    .raddr_a (rs),
    .raddr_b (rt),
    .rdata_a (rs_data),
    .rdata_b (rt_data)
  );

  alu_flags u_alu (
    .clk    (clk),
    .rst_n  (rst_n),
    .run    (run),
    .alu_op (alu_op),
    .a      (rs_data),
    .b      (rt_data),
    .imm8   (imm8),
    .result (wb_data),
    .flags  (flags)
  );

endmodule

`default_nettype wire

// File: verilog/alu_flags.sv
// ALU for add, sub, xor and load-immediate, with the Z/N/V flag register.
// Result is combinational, flags move at the clock edge for add, sub and xor.
`timescale 1ns/1ps
`default_nettype none

module alu_flags (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        run,
  input  wire cpu_pkg::opcode_e            alu_op,
  input  wire logic [cpu_pkg::data_w-1:0]  a,    // rs
  input  wire logic [cpu_pkg::data_w-1:0]  b,    // rt
  input  wire logic [cpu_pkg::imm_w-1:0]   imm8,
  output logic      [cpu_pkg::data_w-1:0]  result,
  output logic      [cpu_pkg::flag_w-1:0]  flags
);

  localparam int msb = cpu_pkg::data_w - 1;

  logic [cpu_pkg::data_w-1:0] sum;
  logic [cpu_pkg::data_w-1:0] diff;
  logic                       add_ovf;
  logic                       sub_ovf;
  logic                       v_next;
  logic                       flag_upd;
  logic [cpu_pkg::flag_w-1:0] flags_next;

  assign sum  = a + b;
  assign diff = a - b;

  // signed overflow, sign of result disagrees with the operands
  assign add_ovf = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
  assign sub_ovf = (a[msb] != b[msb]) && (diff[msb] != a[msb]);

  always_comb begin
    case (alu_op)
      cpu_pkg::op_add: result = sum;
      cpu_pkg::op_sub: result = diff;
      cpu_pkg::op_xor: result = a ^ b;
      cpu_pkg::op_lli: result = {8'b0, imm8}; // zero-extended
      default:         result = '0;           // not written back
    endcase
  end

  always_comb begin
    case (alu_op)
      cpu_pkg::op_add: v_next = add_ovf;
      cpu_pkg::op_sub: v_next = sub_ovf;
      default:         v_next = 1'b0; // xor clears v
    endcase
  end

  // lli leaves the flags alone
  assign flag_upd = run && (alu_op == cpu_pkg::op_add ||
                            alu_op == cpu_pkg::op_sub ||
                            alu_op == cpu_pkg::op_xor);

  always_comb begin
    flags_next                 = '0;
    flags_next[cpu_pkg::flag_z] = (result == '0);
    flags_next[cpu_pkg::flag_n] = result[msb];
    flags_next[cpu_pkg::flag_v] = v_next;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (flag_upd) begin
      flags <= flags_next;
    end
  end

  // x operands reaching the flags would poison every later branch
  a_flags_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(flags));

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// General purpose register file, 16 entries of one word.
// Two combinational read ports and one clocked write port, no bypass.
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       we,
  input  wire logic [cpu_pkg::reg_w-1:0]  waddr,
  input  wire logic [cpu_pkg::data_w-1:0] wdata,
  input  wire logic [cpu_pkg::reg_w-1:0]  raddr_a,
  input  wire logic [cpu_pkg::reg_w-1:0]  raddr_b,
  output logic      [cpu_pkg::data_w-1:0] rdata_a,
  output logic      [cpu_pkg::data_w-1:0] rdata_b
);

  localparam int nregs = 1 << cpu_pkg::reg_w;

  logic [cpu_pkg::data_w-1:0] regs [nregs];

  // all registers clear on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // same-cycle write shows up next cycle
  assign rdata_a = regs[raddr_a]; // rs, also the branch target
  assign rdata_b = regs[raddr_b]; // rt

endmodule

`default_nettype wire

// File: verilog/inst_decode.sv
// Splits the fetched word into fields for the datapath.
// Only alu opcodes write back, and only while the core runs.
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  wire logic [cpu_pkg::data_w-1:0] instr,
  input  wire logic                       run,
  output cpu_pkg::opcode_e                opcode,
  output cpu_pkg::opcode_e                alu_op,
  output cpu_pkg::cond_e                  cond,
  output logic      [cpu_pkg::reg_w-1:0]  rd,
  output logic      [cpu_pkg::reg_w-1:0]  rs,
  output logic      [cpu_pkg::reg_w-1:0]  rt,
  output logic      [cpu_pkg::imm_w-1:0]  imm8,
  output logic                            wb_en
);

  cpu_pkg::opcode_e op;
  logic             is_alu;

  assign op = cpu_pkg::opcode_e'(instr[cpu_pkg::op_msb:cpu_pkg::op_lsb]);

  // register and immediate fields, cond overlaps rd
  assign rd   = instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
  assign rs   = instr[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
  assign rt   = instr[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
  assign imm8 = instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];
  assign cond = cpu_pkg::cond_e'(instr[cpu_pkg::cond_msb:cpu_pkg::cond_lsb]);

  always_comb begin
    case (op)
      cpu_pkg::op_add,
      cpu_pkg::op_sub,
      cpu_pkg::op_xor,
      cpu_pkg::op_lli: is_alu = 1'b1;
      default:         is_alu = 1'b0; // branches, halt, unknown codes
    endcase
  end

  // unknown codes pass with no name, pc unit steps by 2 on them
  assign opcode = op;

  // non-alu codes steer the alu to lli so the flags hold
  assign alu_op = is_alu ? op : cpu_pkg::op_lli;

  assign wb_en = is_alu & run; // no writeback while loading

endmodule

`default_nettype wire

// File: verilog/instr_mem.sv
// Instruction memory, one word per entry, loaded through a write port.
// Fetch is combinational, indexed by the pc byte address.
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
  parameter int imem_depth = 256 // words
) (
  input  wire logic                       clk,
  input  wire logic                       prog_we,
  input  wire logic [cpu_pkg::data_w-1:0] prog_addr, // word index
  input  wire logic [cpu_pkg::data_w-1:0] prog_data,
  input  wire logic [cpu_pkg::data_w-1:0] pc_addr,   // byte address
  output logic      [cpu_pkg::data_w-1:0] instr
);

  localparam int aw = (imem_depth > 1) ? $clog2(imem_depth) : 1;

  logic [cpu_pkg::data_w-1:0] mem [imem_depth];
  logic [aw-1:0]              rd_idx;
  logic                       wr_ok;

  // drop bit 0 and wrap at the depth
  assign rd_idx = aw'({17'b0, pc_addr[cpu_pkg::data_w-1:1]} % imem_depth);
  assign wr_ok  = ({16'b0, prog_addr} < imem_depth); // out of range writes dropped

  always_ff @(posedge clk) begin
    if (prog_we && wr_ok) begin
      mem[aw'(prog_addr)] <= prog_data;
    end
  end

  assign instr = mem[rd_idx];

  // a load beyond the array is a testbench bug
  a_wr_range: assert property (@(posedge clk) prog_we |-> wr_ok)
    else $error("instr_mem write to %0d beyond depth %0d", prog_addr, imem_depth);

endmodule

`default_nettype wire

// File: verilog/pc_unit.sv
// Program counter register and next-pc selection.
// Conditions are checked against the flag register, branches resolve in the same cycle.
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              run,     // gates the pc update
  input  wire cpu_pkg::opcode_e                  opcode,
  input  wire cpu_pkg::cond_e                    cond,
  input  wire logic [cpu_pkg::imm_w-1:0]         imm8,
  input  wire logic [cpu_pkg::flag_w-1:0]        flags,
  input  wire logic [cpu_pkg::data_w-1:0]        branch_reg_addr, // rs data
  output logic      [cpu_pkg::data_w-1:0]        pc_addr,
  output logic                                   halted
);

  logic z_flag, n_flag, v_flag;
  logic cond_pass;
  logic [cpu_pkg::data_w-1:0] plus_two;   // fall-through
  logic [cpu_pkg::data_w-1:0] branch_imm; // pc + 2 + imm8
  logic [cpu_pkg::data_w-1:0] pc_next;

  assign z_flag = flags[cpu_pkg::flag_z];
  assign n_flag = flags[cpu_pkg::flag_n];
  assign v_flag = flags[cpu_pkg::flag_v];

  // condition table, ge keeps the z | ~n form
  always_comb begin
    case (cond)
      cpu_pkg::cond_ne: cond_pass = ~z_flag;
      cpu_pkg::cond_eq: cond_pass = z_flag;
      cpu_pkg::cond_gt: cond_pass = ~z_flag & ~n_flag;
      cpu_pkg::cond_lt: cond_pass = n_flag;
      cpu_pkg::cond_ge: cond_pass = z_flag | ~n_flag;
      cpu_pkg::cond_le: cond_pass = n_flag | z_flag;
      cpu_pkg::cond_ov: cond_pass = v_flag;
      default:          cond_pass = 1'b1; // always
    endcase
  end

  assign plus_two   = pc_addr + 16'd2;
  assign branch_imm = plus_two + {8'b0, imm8}; // imm zero-extended

  // halt wins, then a failed condition falls through
  always_comb begin
    if (opcode == cpu_pkg::op_hlt) begin
      pc_next = pc_addr; // hold
    end else if (!cond_pass) begin
      pc_next = plus_two;
    end else begin
      case (opcode)
        cpu_pkg::op_b:  pc_next = branch_imm;
        cpu_pkg::op_br: pc_next = branch_reg_addr;
        default:        pc_next = plus_two; // alu ops and no-ops
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_addr <= '0;
    end else if (run) begin
      pc_addr <= pc_next;
    end
  end

  assign halted = (opcode == cpu_pkg::op_hlt); // straight from the fetched word

  // even pc stays even unless the target comes from a register or an odd offset
  a_pc_even: assert property (@(posedge clk) disable iff (!rst_n)
    run && !pc_addr[0] && opcode != cpu_pkg::op_br &&
    !(opcode == cpu_pkg::op_b && imm8[0]) |=> !pc_addr[0]);

  // halt under run freezes the pc
  a_halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    run && opcode == cpu_pkg::op_hlt |=> $stable(pc_addr));

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
// Shared definitions for the single-cycle 16-bit core.
// Opcodes, branch conditions, flag bits and instruction field positions.
`default_nettype none

package cpu_pkg;

  localparam int data_w = 16; // one word, data and address

  // 4-bit opcode field, unlisted codes act as no-op
  typedef enum logic [3:0] {
    op_add = 4'b0000,
    op_sub = 4'b0001,
    op_xor = 4'b0010,
    op_lli = 4'b0011,
    op_b   = 4'b1100,
    op_br  = 4'b1101,
    op_hlt = 4'b1111
  } opcode_e;

  // branch conditions, evaluated against z/n/v
  typedef enum logic [2:0] {
    cond_ne = 3'b000,
    cond_eq = 3'b001,
    cond_gt = 3'b010,
    cond_lt = 3'b011,
    cond_ge = 3'b100,
    cond_le = 3'b101,
    cond_ov = 3'b110,
    cond_al = 3'b111
  } cond_e;

  // bit positions in the flag vector
  localparam int flag_w = 3;
  localparam int flag_z = 0;
  localparam int flag_n = 1;
  localparam int flag_v = 2;

  // instruction fields
  localparam int op_msb   = 15;
  localparam int op_lsb   = 12;
  localparam int rd_msb   = 11;
  localparam int rd_lsb   = 8;
  localparam int rs_msb   = 7;
  localparam int rs_lsb   = 4;
  localparam int rt_msb   = 3;
  localparam int rt_lsb   = 0;
  localparam int imm_msb  = 7;
  localparam int imm_lsb  = 0;
  localparam int cond_msb = 10;
  localparam int cond_lsb = 8;
  localparam int reg_w    = 4; // register index width
  localparam int imm_w    = 8;

endpackage

`default_nettype wire
